// ==== tomasulo_cfg.svh ====
`ifndef TOMASULO_CFG_SVH
`define TOMASULO_CFG_SVH

// Datapath word width
`define TOM_XLEN 32

// Width of the result tags carried on the CDB
`define TOM_TAG_W 6

// Data cache size in words
`define TOM_DC_DEPTH 256

// Multiplier pipeline depth, one issue per cycle
`define TOM_MULT_LAT 3

// Divider occupancy in cycles from start to quotient
`define TOM_DIV_LAT 6

`endif

// ==== issue_pkg.sv ====
`default_nettype none

`include "tomasulo_cfg.svh"

package issue_pkg;

   // ALU operations, encoded like the R-type funct field where one exists
   typedef enum logic [5:0] {
      ALU_SLL = 6'h00,
      ALU_SRL = 6'h02,
      ALU_BEQ = 6'h04,
      ALU_BNE = 6'h05,
      ALU_ADD = 6'h20,
      ALU_SUB = 6'h22,
      ALU_AND = 6'h24,
      ALU_OR  = 6'h25,
      ALU_XOR = 6'h26,
      ALU_SLT = 6'h2a
   } alu_op_e;

   typedef struct packed {
      alu_op_e                opcode;
      logic [`TOM_XLEN-1:0]   rs;
      logic [`TOM_XLEN-1:0]   rt;
      logic [`TOM_TAG_W-1:0]  tag;
   } int_req_t;

   // Load when store is low, the tag names the load destination
   typedef struct packed {
      logic                   store;
      logic [`TOM_XLEN-1:0]   addr;
      logic [`TOM_XLEN-1:0]   data;
      logic [`TOM_TAG_W-1:0]  tag;
   } ls_req_t;

   // Shared by the multiply and divide stations
   typedef struct packed {
      logic [`TOM_XLEN-1:0]   rs;
      logic [`TOM_XLEN-1:0]   rt;
      logic [`TOM_TAG_W-1:0]  tag;
   } md_req_t;

   typedef struct packed {
      logic                   valid;
      logic [`TOM_XLEN-1:0]   data;
      logic [`TOM_TAG_W-1:0]  tag;
      logic                   branch;
      logic                   branch_taken;
   } cdb_t;

   typedef struct packed {
      logic                   carry;
      logic                   overflow;
      logic                   branch;
      logic                   taken;
   } alu_flags_t;

endpackage

`default_nettype wire

// ==== int_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_cfg.svh"

module int_alu
   import issue_pkg::*;
(
   input  int_req_t              req,
   output logic [`TOM_XLEN-1:0]  result,
   output alu_flags_t            flags
);

   localparam int SHAMT_W = $clog2(`TOM_XLEN);

   logic [`TOM_XLEN:0]    sum_ext;
   logic [`TOM_XLEN:0]    diff_ext;
   logic                  rs_msb;
   logic                  rt_msb;
   logic [SHAMT_W-1:0]    shamt;

   // Extra top bit catches the carry out
   assign sum_ext  = {1'b0, req.rs} + {1'b0, req.rt};
   // Two's complement subtract, carry set means no borrow
   assign diff_ext = {1'b0, req.rs} + {1'b0, ~req.rt} + 1'b1;

   assign rs_msb = req.rs[`TOM_XLEN-1];
   assign rt_msb = req.rt[`TOM_XLEN-1];
   assign shamt  = req.rt[SHAMT_W-1:0];

   always_comb begin
      result = '0;
      flags  = '0;
      case (req.opcode)
         ALU_ADD: begin
            result         = sum_ext[`TOM_XLEN-1:0];
            flags.carry    = sum_ext[`TOM_XLEN];
            // Same-sign operands giving an opposite-sign sum
            flags.overflow = (rs_msb == rt_msb) && (sum_ext[`TOM_XLEN-1] != rs_msb);
         end
         ALU_SUB: begin
            result         = diff_ext[`TOM_XLEN-1:0];
            flags.carry    = diff_ext[`TOM_XLEN];
            flags.overflow = (rs_msb != rt_msb) && (diff_ext[`TOM_XLEN-1] != rs_msb);
         end
         ALU_AND: result = req.rs & req.rt;
         ALU_OR:  result = req.rs | req.rt;
         ALU_XOR: result = req.rs ^ req.rt;
         ALU_SLT: begin
            result = {{(`TOM_XLEN-1){1'b0}}, ($signed(req.rs) < $signed(req.rt))};
         end
         ALU_SLL: result = req.rs << shamt;
         ALU_SRL: result = req.rs >> shamt;
         // Branches only resolve the condition, data stays zero
         ALU_BEQ: begin
            flags.branch = 1'b1;
            flags.taken  = (req.rs == req.rt);
         end
         ALU_BNE: begin
            flags.branch = 1'b1;
            flags.taken  = (req.rs != req.rt);
         end
         default: begin
            result = '0;
            flags  = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== mult_pipe.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_cfg.svh"

module mult_pipe
   import issue_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   start,
   input  md_req_t                req,
   output logic [`TOM_XLEN-1:0]   result,
   output logic [`TOM_TAG_W-1:0]  tag
);

   typedef struct packed {
      logic [`TOM_XLEN-1:0]   data;
      logic [`TOM_TAG_W-1:0]  tag;
   } stage_t;

   logic [`TOM_XLEN-1:0]      product;
   stage_t                    entry;
   stage_t                    stage_q [`TOM_MULT_LAT];
   // Occupancy of every stage except the last
   logic [`TOM_MULT_LAT-2:0]  occ_q;

   // Only the low word of the product is kept
   assign product = req.rs * req.rt;
   assign entry   = start ? {product, req.tag} : '0;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         occ_q <= '0;
      end else begin
         occ_q <= {occ_q[`TOM_MULT_LAT-3:0], start};
      end
   end

   always_ff @(posedge clk) begin
      stage_q[0] <= entry;
      for (int k = 1; k < `TOM_MULT_LAT; k++) begin
         stage_q[k] <= occ_q[k-1] ? stage_q[k-1] : '0;
      end
   end

   assign result = stage_q[`TOM_MULT_LAT-1].data;
   assign tag    = stage_q[`TOM_MULT_LAT-1].tag;

endmodule

`default_nettype wire

// ==== div_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_cfg.svh"

module div_unit
   import issue_pkg::*;
(
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   start,
   input  md_req_t                req,
   output logic                   busy,
   output logic [`TOM_XLEN-1:0]   quotient,
   output logic [`TOM_TAG_W-1:0]  tag
);

   localparam int CNT_W = $clog2(`TOM_DIV_LAT + 1);

   logic [CNT_W-1:0]      count_q;
   logic [`TOM_XLEN-1:0]  dividend_q;
   logic [`TOM_XLEN-1:0]  divisor_q;
   logic                  last_step;

   // Count runs LAT-1 down to zero, so the quotient is out LAT cycles after start
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count_q <= '0;
      end else if (start) begin
         count_q <= CNT_W'(`TOM_DIV_LAT - 1);
      end else if (count_q != '0) begin
         count_q <= count_q - 1'b1;
      end
   end

   assign last_step = (count_q == CNT_W'(1));

   always_ff @(posedge clk) begin
      if (start) begin
         dividend_q <= req.rs;
         divisor_q  <= req.rt;
         tag        <= req.tag;
      end
      if (last_step) begin
         // Divide by zero saturates to all ones
         if (divisor_q == '0) begin
            quotient <= '1;
         end else begin
            quotient <= dividend_q / divisor_q;
         end
      end
   end

   // Drops in the cycle the quotient is presented, so a new start may follow at once
   assign busy = (count_q != '0);

endmodule

`default_nettype wire

// ==== data_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_cfg.svh"

module data_cache (
   input  logic                  clk,
   input  logic                  wen,
   input  logic [`TOM_XLEN-1:0]  addr,
   input  logic [`TOM_XLEN-1:0]  wdata,
   output logic [`TOM_XLEN-1:0]  rdata
);

   localparam int IDX_W = $clog2(`TOM_DC_DEPTH);

   logic [`TOM_XLEN-1:0]  mem [`TOM_DC_DEPTH];
   logic [IDX_W-1:0]      index;

   // Word addressed, skip the byte offset
   assign index = addr[IDX_W+1:2];

   // Asynchronous read port for loads
   assign rdata = mem[index];

   always_ff @(posedge clk) begin
      if (wen) begin
         mem[index] <= wdata;
      end
   end

endmodule

`default_nettype wire

// ==== issue_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_cfg.svh"

module issue_unit
   import issue_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  int_req_t  int_req,
   input  logic      int_ready,
   input  ls_req_t   ls_req,
   input  logic      ls_ready,
   input  md_req_t   mult_req,
   input  logic      mult_ready,
   input  md_req_t   div_req,
   input  logic      div_ready,
   output logic      int_done,
   output logic      ls_done,
   output logic      mult_done,
   output logic      div_done,
   output cdb_t      cdb,
   output logic      alu_carry,
   output logic      alu_overflow
);

   localparam int MULT_LAT = `TOM_MULT_LAT;
   localparam int DIV_LAT  = `TOM_DIV_LAT;
   // Entry k marks the CDB cycle k cycles ahead as taken
   localparam int RES_W    = DIV_LAT + 1;

   logic                  alu_grant;
   logic                  ls_grant;
   logic                  mult_grant;
   logic                  div_grant;
   logic                  div_busy;
   logic                  both_ready;
   logic                  alu_first_q;

   logic [RES_W-1:0]      slot_q;
   logic [RES_W-1:0]      slot_d;
   logic [MULT_LAT-1:0]   mult_line_q;
   logic [DIV_LAT-1:0]    div_line_q;

   logic [`TOM_XLEN-1:0]  alu_result;
   alu_flags_t            alu_flags;
   logic [`TOM_XLEN-1:0]  ls_rdata;
   logic [`TOM_XLEN-1:0]  mult_result;
   logic [`TOM_TAG_W-1:0] mult_tag;
   logic [`TOM_XLEN-1:0]  div_quotient;
   logic [`TOM_TAG_W-1:0] div_tag;
   cdb_t                  cdb_d;

   assign both_ready = int_ready & ls_ready;

   // Divide claims its slot first, later grants see it in the vector
   always_comb begin
      div_grant  = div_ready & ~div_busy;
      mult_grant = mult_ready & ~slot_q[MULT_LAT+1];
      alu_grant  = int_ready & ~slot_q[1] & (~ls_ready | alu_first_q);
      ls_grant   = ls_ready & ~slot_q[1] & (~int_ready | ~alu_first_q);
   end

   always_comb begin
      slot_d           = {1'b0, slot_q[RES_W-1:1]};
      slot_d[DIV_LAT]  = slot_d[DIV_LAT] | div_grant;
      slot_d[MULT_LAT] = slot_d[MULT_LAT] | mult_grant;
      slot_d[0]        = slot_d[0] | alu_grant | ls_grant;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         alu_first_q <= 1'b1;
         slot_q      <= '0;
         mult_line_q <= '0;
         div_line_q  <= '0;
      end else begin
         // Priority swaps whenever ALU and load/store meet
         alu_first_q <= alu_first_q ^ both_ready;
         slot_q      <= slot_d;
         mult_line_q <= {mult_line_q[MULT_LAT-2:0], mult_grant};
         div_line_q  <= {div_line_q[DIV_LAT-2:0], div_grant};
      end
   end

   assign int_done  = alu_grant;
   assign ls_done   = ls_grant;
   assign mult_done = mult_grant;
   assign div_done  = div_grant;

   // Reservations keep these sources one-hot in any cycle
   always_comb begin
      cdb_d = '0;
      if (div_line_q[DIV_LAT-1]) begin
         cdb_d.valid = 1'b1;
         cdb_d.data  = div_quotient;
         cdb_d.tag   = div_tag;
      end else if (mult_line_q[MULT_LAT-1]) begin
         cdb_d.valid = 1'b1;
         cdb_d.data  = mult_result;
         cdb_d.tag   = mult_tag;
      end else if (alu_grant) begin
         cdb_d.valid        = ~alu_flags.branch;
         cdb_d.data         = alu_result;
         cdb_d.tag          = int_req.tag;
         cdb_d.branch       = alu_flags.branch;
         cdb_d.branch_taken = alu_flags.taken;
      end else if (ls_grant && !ls_req.store) begin
         cdb_d.valid = 1'b1;
         cdb_d.data  = ls_rdata;
         cdb_d.tag   = ls_req.tag;
      end
   end

   // Load only around reserved slots, otherwise the register already holds zero
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cdb <= '0;
      end else if (slot_d[0] || slot_q[0]) begin
         cdb <= cdb_d;
      end
   end

   assign alu_carry    = alu_flags.carry;
   assign alu_overflow = alu_flags.overflow;

   int_alu u_int_alu (
      .req    (int_req),
      .result (alu_result),
      .flags  (alu_flags)
   );

   mult_pipe u_mult_pipe (
      .clk    (clk),
      .arst_n (arst_n),
      .start  (mult_grant),
      .req    (mult_req),
      .result (mult_result),
      .tag    (mult_tag)
   );

   div_unit u_div_unit (
      .clk      (clk),
      .arst_n   (arst_n),
      .start    (div_grant),
      .req      (div_req),
      .busy     (div_busy),
      .quotient (div_quotient),
      .tag      (div_tag)
   );

   // Store bit doubles as the write enable
   data_cache u_data_cache (
      .clk   (clk),
      .wen   (ls_grant & ls_req.store),
      .addr  (ls_req.addr),
      .wdata (ls_req.data),
      .rdata (ls_rdata)
   );

endmodule

`default_nettype wire

// ==== issue_unit_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_cfg.svh"

module issue_unit_properties
   import issue_pkg::*;
(
   input logic  clk,
   input logic  arst_n,
   input logic  int_done,
   input logic  ls_done,
   input logic  div_done,
   input cdb_t  cdb
);

   localparam int DIV_LAT = `TOM_DIV_LAT;
   localparam int GAP_W   = $clog2(DIV_LAT + 1);

   // Cycles since the last divide grant, saturating at the divider latency
   logic [GAP_W-1:0]  div_gap_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         div_gap_q <= GAP_W'(DIV_LAT);
      end else if (div_done) begin
         div_gap_q <= GAP_W'(1);
      end else if (div_gap_q < GAP_W'(DIV_LAT)) begin
         div_gap_q <= div_gap_q + 1'b1;
      end
   end

   // ALU and load/store share the T+1 slot
   shared_slot_single_grant: assert property (@(posedge clk) disable iff (!arst_n)
      !(int_done && ls_done))
      else $error("ALU and load/store granted in the same cycle");

   div_grant_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
      div_done |-> (div_gap_q >= GAP_W'(DIV_LAT)))
      else $error("Divide granted while the divider is busy");

   // Branch outcomes never carry a register result
   cdb_valid_or_branch: assert property (@(posedge clk) disable iff (!arst_n)
      !(cdb.valid && cdb.branch))
      else $error("CDB valid and branch high together");

endmodule

bind issue_unit issue_unit_properties u_props (
   .clk      (clk),
   .arst_n   (arst_n),
   .int_done (int_done),
   .ls_done  (ls_done),
   .div_done (div_done),
   .cdb      (cdb)
);

`default_nettype wire

// ==== tb_issue_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "tomasulo_cfg.svh"

module tb_issue_unit
   import issue_pkg::*;
();

   localparam int N_CYCLES    = 4000;
   localparam int DRAIN_LIMIT = 200;
   localparam int TAG_W       = `TOM_TAG_W;
   localparam int IDX_HI      = $clog2(`TOM_DC_DEPTH) + 1;

   logic      clk          = 1'b0;
   logic      arst_n       = 1'b0;
   int_req_t  int_req      = '0;
   logic      int_ready    = 1'b0;
   ls_req_t   ls_req       = '0;
   logic      ls_ready     = 1'b0;
   md_req_t   mult_req     = '0;
   logic      mult_ready   = 1'b0;
   md_req_t   div_req      = '0;
   logic      div_ready    = 1'b0;
   logic      int_done;
   logic      ls_done;
   logic      mult_done;
   logic      div_done;
   cdb_t      cdb;
   logic      alu_carry;
   logic      alu_overflow;

   // Reference model state owned by the monitor
   cdb_t                  exp_at [int];
   logic [`TOM_XLEN-1:0]  shadow [`TOM_DC_DEPTH];
   bit                    written [`TOM_DC_DEPTH];
   logic                  alu_first    = 1'b1;
   int                    cyc          = 0;
   int                    div_free_cyc = 0;
   int                    last_mult    = -10;
   logic                  int_seen     = 1'b0;
   logic                  ls_seen      = 1'b0;
   logic                  mult_seen    = 1'b0;
   logic                  div_seen     = 1'b0;
   int                    err_value    = 0;
   int                    err_other    = 0;
   int                    n_contend    = 0;
   int                    n_divzero    = 0;
   int                    n_mult_b2b   = 0;
   int                    n_load       = 0;
   int                    n_branch     = 0;

   logic                  stim_on  = 1'b0;
   int                    timeouts = 0;
   int                    cov_miss = 0;

   alu_op_e op_list [10] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
                             ALU_SLT, ALU_SLL, ALU_SRL, ALU_BEQ, ALU_BNE};

   issue_unit UUT (.*);

   always #5 clk = ~clk;

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (actual !== expected) begin
         err_value++;
         $display("[FAIL] %s cycle %0d expected %h actual %h", name, cyc, expected, actual);
      end
   endtask

   // Expected ALU outcome with overflow found by range on a wider signed sum
   task automatic alu_reference(input int_req_t r, output logic [`TOM_XLEN-1:0] data,
                                output alu_flags_t fl);
      longint             wide;
      data = '0;
      fl   = '0;
      case (r.opcode)
         ALU_ADD: begin
            wide        = longint'($signed(r.rs)) + longint'($signed(r.rt));
            data        = r.rs + r.rt;
            // Unsigned wrap shows as a sum below the first operand
            fl.carry    = (data < r.rs);
            fl.overflow = (wide != longint'($signed(data)));
         end
         ALU_SUB: begin
            wide        = longint'($signed(r.rs)) - longint'($signed(r.rt));
            data        = r.rs - r.rt;
            fl.carry    = (r.rs >= r.rt);
            fl.overflow = (wide != longint'($signed(data)));
         end
         ALU_AND: data = r.rs & r.rt;
         ALU_OR:  data = r.rs | r.rt;
         ALU_XOR: data = r.rs ^ r.rt;
         ALU_SLT: data = ($signed(r.rs) < $signed(r.rt)) ? 32'd1 : 32'd0;
         ALU_SLL: data = r.rs << r.rt[4:0];
         ALU_SRL: data = r.rs >> r.rt[4:0];
         ALU_BEQ: begin
            fl.branch = 1'b1;
            fl.taken  = (r.rs == r.rt);
         end
         ALU_BNE: begin
            fl.branch = 1'b1;
            fl.taken  = (r.rs != r.rt);
         end
         default: data = '0;
      endcase
   endtask

   task automatic schedule(input int at, input cdb_t e);
      if (exp_at.exists(at)) begin
         err_other++;
         $display("Two results were granted the same CDB cycle %0d", at);
      end else begin
         exp_at[at] = e;
      end
   endtask

   function automatic int_req_t rand_int_req();
      int_req_t r;
      r.opcode = op_list[$urandom_range(9, 0)];
      r.rs     = $urandom;
      // Equal operands now and then so both branch outcomes occur
      r.rt     = ($urandom_range(3, 0) == 0) ? r.rs : $urandom;
      r.tag    = TAG_W'($urandom);
      return r;
   endfunction

   function automatic ls_req_t rand_ls_req();
      ls_req_t         r;
      logic [3:0]      word;
      word    = 4'($urandom_range(15, 0));
      // Loads only from words that hold a stored value
      r.store = !written[word] || ($urandom_range(1, 0) == 1);
      r.addr  = {26'd0, word, 2'($urandom)};
      r.data  = $urandom;
      r.tag   = TAG_W'($urandom);
      return r;
   endfunction

   function automatic md_req_t rand_md_req(input bit div_mode);
      md_req_t r;
      r.rs  = $urandom;
      r.rt  = $urandom >> $urandom_range(31, 0);
      if (div_mode && $urandom_range(7, 0) == 0) begin
         r.rt = '0;
      end
      r.tag = TAG_W'($urandom);
      return r;
   endfunction

   // Stations hold a request until its done pulse was seen
   always @(posedge clk) begin
      if (!int_ready || int_seen) begin
         int_req   <= rand_int_req();
         int_ready <= stim_on && ($urandom_range(1, 0) == 1);
      end
      if (!ls_ready || ls_seen) begin
         ls_req   <= rand_ls_req();
         ls_ready <= stim_on && ($urandom_range(1, 0) == 1);
      end
      if (!mult_ready || mult_seen) begin
         mult_req   <= rand_md_req(1'b0);
         mult_ready <= stim_on && ($urandom_range(3, 0) != 0);
      end
      if (!div_ready || div_seen) begin
         div_req   <= rand_md_req(1'b1);
         div_ready <= stim_on && ($urandom_range(2, 0) == 0);
      end
   end

   always @(negedge clk) begin : monitor
      logic                  slot1_free;
      logic                  exp_int;
      logic                  exp_ls;
      logic                  exp_mult;
      logic                  exp_div;
      logic [`TOM_XLEN-1:0]  alu_data;
      alu_flags_t            alu_fl;
      logic [63:0]           prod;
      cdb_t                  e;
      if (arst_n) begin
         if (exp_at.exists(cyc)) begin
            check_value("cdb entry", exp_at[cyc], cdb);
            exp_at.delete(cyc);
         end else begin
            check_value("idle cdb valid and branch", 64'd0, {cdb.valid, cdb.branch});
         end
         slot1_free = !exp_at.exists(cyc + 1);
         exp_int    = int_ready && slot1_free && (!ls_ready || alu_first);
         exp_ls     = ls_ready && slot1_free && (!int_ready || !alu_first);
         exp_mult   = mult_ready && !exp_at.exists(cyc + 4);
         exp_div    = div_ready && (cyc >= div_free_cyc);
         check_value("int_done", exp_int, int_done);
         check_value("ls_done", exp_ls, ls_done);
         check_value("mult_done", exp_mult, mult_done);
         check_value("div_done", exp_div, div_done);
         if (int_ready && ls_ready) begin
            alu_first = !alu_first;
            n_contend++;
         end
         if (int_done) begin
            alu_reference(int_req, alu_data, alu_fl);
            check_value("alu_carry", alu_fl.carry, alu_carry);
            check_value("alu_overflow", alu_fl.overflow, alu_overflow);
            e              = '0;
            e.valid        = !alu_fl.branch;
            e.data         = alu_data;
            e.tag          = int_req.tag;
            e.branch       = alu_fl.branch;
            e.branch_taken = alu_fl.taken;
            n_branch       = n_branch + int'(alu_fl.branch);
            schedule(cyc + 1, e);
         end
         if (ls_done && ls_req.store) begin
            shadow[ls_req.addr[IDX_HI:2]]  = ls_req.data;
            written[ls_req.addr[IDX_HI:2]] = 1'b1;
         end else if (ls_done) begin
            e       = '0;
            e.valid = 1'b1;
            e.data  = shadow[ls_req.addr[IDX_HI:2]];
            e.tag   = ls_req.tag;
            n_load++;
            schedule(cyc + 1, e);
         end
         if (mult_done) begin
            prod    = {32'd0, mult_req.rs} * {32'd0, mult_req.rt};
            e       = '0;
            e.valid = 1'b1;
            e.data  = prod[`TOM_XLEN-1:0];
            e.tag   = mult_req.tag;
            if (last_mult == cyc - 1) n_mult_b2b++;
            last_mult = cyc;
            schedule(cyc + 4, e);
         end
         if (div_done) begin
            e       = '0;
            e.valid = 1'b1;
            e.data  = (div_req.rt == '0) ? '1 : div_req.rs / div_req.rt;
            e.tag   = div_req.tag;
            if (div_req.rt == '0) n_divzero++;
            div_free_cyc = cyc + 6;
            schedule(cyc + 7, e);
         end
         cyc++;
      end
      int_seen  = arst_n && int_done;
      ls_seen   = arst_n && ls_done;
      mult_seen = arst_n && mult_done;
      div_seen  = arst_n && div_done;
   end

   initial begin : main
      int wait_cnt;
      int total;
      void'($urandom(32'h34b4_b537));
      repeat (3) @(posedge clk);
      arst_n  <= 1'b1;
      stim_on <= 1'b1;
      repeat (N_CYCLES) @(posedge clk);
      stim_on <= 1'b0;
      // Let held requests and in-flight results finish
      wait_cnt = 0;
      while ((int_ready || ls_ready || mult_ready || div_ready || exp_at.size() != 0)
             && wait_cnt < DRAIN_LIMIT) begin
         @(posedge clk);
         wait_cnt++;
      end
      if (wait_cnt >= DRAIN_LIMIT) begin
         timeouts++;
         $display("Timeout: requests or CDB results still pending after the drain");
      end
      repeat (2) @(posedge clk);
      if (n_contend == 0 || n_divzero == 0 || n_mult_b2b == 0) begin
         cov_miss++;
         $display("Stimulus missed contention, divide by zero or back to back multiplies");
      end
      if (n_load == 0 || n_branch == 0) begin
         cov_miss++;
         $display("Stimulus produced no loads or no branches");
      end
      total = err_value + err_other + cov_miss + timeouts;
      $display("Errors: %0d value, %0d protocol, %0d coverage, %0d timeout",
               err_value, err_other, cov_miss, timeouts);
      if (total == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
issue_pkg.sv
int_alu.sv
mult_pipe.sv
div_unit.sv
data_cache.sv
issue_unit.sv
issue_unit_properties.sv
tb_issue_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_issue_unit -f flist.f -Mdir obj_dir \
   || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_issue_unit 2>&1)"
echo "$sim_out"

# Pass only when the testbench printed its pass line
echo "$sim_out" | grep -qx "ALL CHECKS PASSED" && exit 0 || exit 1
